// ==== common/aes_pkg.sv ====
// aes_pkg: shared widths, block and word types, request struct and operation codes of the AES decrypt core.
package aes_pkg;

	// AES-128 runs ten rounds after the initial key addition.
	localparam int NUM_ROUNDS = 10;
	localparam int BLOCK_W = 128;
	localparam int WORD_W = 32;

	// byte 0 of a block sits in the top bits, as in FIPS-197.
	typedef logic [BLOCK_W-1:0] block_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [7:0] byte_t;

	// round index, 0 to NUM_ROUNDS.
	typedef logic [3:0] round_cnt_t;

	// one decryption request as it crosses the input handshake.
	typedef struct packed {
		block_t key;
		block_t ciphertext;
	} dec_req_t;

	// commands to the round key register.
	typedef enum logic [1:0] {
		KEY_HOLD,
		KEY_LOAD,
		KEY_FWD,
		KEY_BWD
	} key_op_t;

	// commands to the state register of the round datapath.
	typedef enum logic [2:0] {
		PATH_HOLD,
		PATH_LOAD,
		PATH_ADD_KEY,
		PATH_ROUND,
		PATH_FINAL
	} path_op_t;

endpackage

// ==== hw/inv_round/inv_sbox.sv ====
// inv_sbox: inverse AES S-box lookup for one byte.
`timescale 1ns/1ns

module inv_sbox (
	input aes_pkg::byte_t in_byte,
	output aes_pkg::byte_t out_byte
);

	logic [0:15][7:0] row;

	// one table row per high nibble, indexed by the low nibble below.
	always_comb begin
		case (in_byte[7:4])
			4'h0: row = 128'h52096ad53036a538bf40a39e81f3d7fb;
			4'h1: row = 128'h7ce339829b2fff87348e4344c4dee9cb;
			4'h2: row = 128'h547b9432a6c2233dee4c950b42fac34e;
			4'h3: row = 128'h082ea16628d924b2765ba2496d8bd125;
			4'h4: row = 128'h72f8f66486689816d4a45ccc5d65b692;
			4'h5: row = 128'h6c704850fdedb9da5e154657a78d9d84;
			4'h6: row = 128'h90d8ab008cbcd30af7e45805b8b34506;
			4'h7: row = 128'hd02c1e8fca3f0f02c1afbd0301138a6b;
			4'h8: row = 128'h3a9111414f67dcea97f2cfcef0b4e673;
			4'h9: row = 128'h96ac7422e7ad3585e2f937e81c75df6e;
			4'ha: row = 128'h47f11a711d29c5896fb7620eaa18be1b;
			4'hb: row = 128'hfc563e4bc6d279209adbc0fe78cd5af4;
			4'hc: row = 128'h1fdda8338807c731b11210592780ec5f;
			4'hd: row = 128'h60517fa919b54a0d2de57a9f93c99cef;
			4'he: row = 128'ha0e03b4dae2af5b0c8ebbb3c83539961;
			default: row = 128'h172b047eba77d626e169146355210c7d;
		endcase
	end

	assign out_byte = row[in_byte[3:0]];

endmodule

// ==== hw/inv_round/inv_mix_column.sv ====
// inv_mix_column: InvMixColumns on one 32-bit column over GF(2^8).
`timescale 1ns/1ns

module inv_mix_column (
	input aes_pkg::word_t column,
	output aes_pkg::word_t mixed
);
	import aes_pkg::*;

	// multiply by x, reduced modulo 0x11b.
	function automatic byte_t xtime(input byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	byte_t m9 [4];
	byte_t mb [4];
	byte_t md [4];
	byte_t me [4];

	for (genvar i = 0; i < 4; i++) begin : g_mul
		byte_t a, x2, x4, x8;

		assign a = column[31-8*i -: 8];
		assign x2 = xtime(a);
		assign x4 = xtime(x2);
		assign x8 = xtime(x4);
		assign m9[i] = x8 ^ a;
		assign mb[i] = x8 ^ x2 ^ a;
		assign md[i] = x8 ^ x4 ^ a;
		assign me[i] = x8 ^ x4 ^ x2;
	end

	assign mixed = {me[0] ^ mb[1] ^ md[2] ^ m9[3],
		m9[0] ^ me[1] ^ mb[2] ^ md[3],
		md[0] ^ m9[1] ^ me[2] ^ mb[3],
		mb[0] ^ md[1] ^ m9[2] ^ me[3]};

endmodule

// ==== hw/inv_round/inv_round_path.sv ====
// inv_round_path: state register that applies one full inverse AES round per cycle.
`timescale 1ns/1ns

module inv_round_path (
	input logic Clk,
	input logic arst_n,
	input aes_pkg::path_op_t path_op,
	input aes_pkg::block_t ciphertext,
	input aes_pkg::block_t round_key,
	output aes_pkg::block_t state
);
	import aes_pkg::*;

	block_t shifted, subbed, keyed, mixed;

	// byte i is row i%4 of column i/4; InvShiftRows moves row r right by r columns.
	for (genvar i = 0; i < 16; i++) begin : g_byte
		assign shifted[127-8*i -: 8] =
			state[127-8*(4*(((i/4) + 4 - (i%4)) % 4) + (i%4)) -: 8];

		inv_sbox u_inv_sbox (
			.in_byte(shifted[127-8*i -: 8]),
			.out_byte(subbed[127-8*i -: 8])
		);
	end

	assign keyed = subbed ^ round_key;

	for (genvar c = 0; c < 4; c++) begin : g_col
		inv_mix_column u_inv_mix_column (
			.column(keyed[127-32*c -: 32]),
			.mixed(mixed[127-32*c -: 32])
		);
	end

	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= '0;
		end else begin
			case (path_op)
				PATH_LOAD: state <= ciphertext;
				PATH_ADD_KEY: state <= state ^ round_key;
				PATH_ROUND: state <= mixed;
				// the last round skips InvMixColumns.
				PATH_FINAL: state <= keyed;
				default: state <= state;
			endcase
		end
	end

endmodule

// ==== hw/key_schedule/sbox_word.sv ====
// sbox_word: forward AES S-box applied to each byte of a 32-bit word.
`timescale 1ns/1ns

module sbox_word (
	input aes_pkg::word_t word,
	output aes_pkg::word_t subst
);
	import aes_pkg::*;

	// the high nibble picks a table row and the low nibble the byte in it.
	function automatic byte_t sbox(input byte_t b);
		logic [0:15][7:0] row;
		case (b[7:4])
			4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
			4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
			4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
			4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
			4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
			4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
			4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
			4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
			4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
			4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
			4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
			4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
			4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
			4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
			4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
			default: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
		endcase
		return row[b[3:0]];
	endfunction

	assign subst = {sbox(word[31:24]), sbox(word[23:16]), sbox(word[15:8]), sbox(word[7:0])};

endmodule

// ==== hw/key_schedule/key_schedule.sv ====
// key_schedule: single round key register that steps forward or backward through the AES-128 schedule.
`timescale 1ns/1ns

module key_schedule (
	input logic Clk,
	input logic arst_n,
	input aes_pkg::key_op_t key_op,
	input aes_pkg::round_cnt_t round_idx,
	input aes_pkg::block_t cipher_key,
	output aes_pkg::block_t round_key
);
	import aes_pkg::*;

	block_t key_q;
	word_t w0, w1, w2, w3;
	word_t n0, n1, n2, n3;
	word_t prev_w3, sub_in, sub_out, temp;
	byte_t rcon;

	assign {w0, w1, w2, w3} = key_q;

	// stepping back, the previous last word falls out of the two last words.
	assign prev_w3 = w3 ^ w2;
	assign sub_in = (key_op == KEY_BWD) ? prev_w3 : w3;

	sbox_word u_sbox_word (
		.word({sub_in[23:0], sub_in[31:24]}),
		.subst(sub_out)
	);

	always_comb begin
		case (round_idx)
			4'd1: rcon = 8'h01;
			4'd2: rcon = 8'h02;
			4'd3: rcon = 8'h04;
			4'd4: rcon = 8'h08;
			4'd5: rcon = 8'h10;
			4'd6: rcon = 8'h20;
			4'd7: rcon = 8'h40;
			4'd8: rcon = 8'h80;
			4'd9: rcon = 8'h1b;
			4'd10: rcon = 8'h36;
			default: rcon = 8'h00;
		endcase
	end

	assign temp = sub_out ^ {rcon, 24'h000000};

	assign n0 = w0 ^ temp;
	assign n1 = w1 ^ n0;
	assign n2 = w2 ^ n1;
	assign n3 = w3 ^ n2;

	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			key_q <= '0;
		end else begin
			case (key_op)
				KEY_LOAD: key_q <= cipher_key;
				KEY_FWD: key_q <= {n0, n1, n2, n3};
				KEY_BWD: key_q <= {w0 ^ temp, w1 ^ w0, w2 ^ w1, prev_w3};
				default: key_q <= key_q;
			endcase
		end
	end

	assign round_key = key_q;

endmodule

// ==== hw/aes_decrypt_ctrl.sv ====
// aes_decrypt_ctrl: phase FSM that sequences key expansion and the inverse rounds.
`timescale 1ns/1ns

module aes_decrypt_ctrl (
	input logic Clk,
	input logic arst_n,
	input logic in_valid,
	output logic in_ready,
	output logic out_valid,
	input logic out_ready,
	output aes_pkg::key_op_t key_op,
	output aes_pkg::path_op_t path_op,
	output aes_pkg::round_cnt_t round_idx
);
	import aes_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		EXPAND,
		INIT_ADD,
		ROUNDS,
		DONE
	} phase_t;

	phase_t phase;
	round_cnt_t cnt;

	// the counter runs up to NUM_ROUNDS while expanding, then back down to zero.
	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			phase <= IDLE;
			cnt <= '0;
		end else begin
			case (phase)
				IDLE: begin
					cnt <= 4'd1;
					if (in_valid) begin
						phase <= EXPAND;
					end
				end
				EXPAND: begin
					if (cnt == NUM_ROUNDS) begin
						phase <= INIT_ADD;
					end else begin
						cnt <= cnt + 4'd1;
					end
				end
				INIT_ADD: begin
					cnt <= cnt - 4'd1;
					phase <= ROUNDS;
				end
				ROUNDS: begin
					// round zero is the final round.
					if (cnt == '0) begin
						phase <= DONE;
					end else begin
						cnt <= cnt - 4'd1;
					end
				end
				DONE: begin
					if (out_ready) begin
						phase <= IDLE;
					end
				end
				default: phase <= IDLE;
			endcase
		end
	end

	// while idle both registers follow the request, so the accepting edge captures it.
	always_comb begin
		key_op = KEY_HOLD;
		path_op = PATH_HOLD;
		case (phase)
			IDLE: begin
				key_op = KEY_LOAD;
				path_op = PATH_LOAD;
			end
			EXPAND: key_op = KEY_FWD;
			INIT_ADD: begin
				key_op = KEY_BWD;
				path_op = PATH_ADD_KEY;
			end
			ROUNDS: begin
				if (cnt == '0) begin
					path_op = PATH_FINAL;
				end else begin
					key_op = KEY_BWD;
					path_op = PATH_ROUND;
				end
			end
			default: ;
		endcase
	end

	assign round_idx = cnt;
	assign in_ready = (phase == IDLE);
	assign out_valid = (phase == DONE);

endmodule

// ==== hw/aes_decrypt.sv ====
// aes_decrypt: iterative AES-128 decryption core with valid/ready on input and output.
`timescale 1ns/1ns

module aes_decrypt (
	input logic Clk,
	input logic arst_n,
	input logic in_valid,
	output logic in_ready,
	input aes_pkg::dec_req_t req,
	output logic out_valid,
	input logic out_ready,
	output aes_pkg::block_t plaintext
);
	import aes_pkg::*;

	key_op_t key_op;
	path_op_t path_op;
	round_cnt_t round_idx;
	block_t round_key;

	aes_decrypt_ctrl u_ctrl (
		.Clk(Clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.key_op(key_op),
		.path_op(path_op),
		.round_idx(round_idx)
	);

	key_schedule u_key_schedule (
		.Clk(Clk),
		.arst_n(arst_n),
		.key_op(key_op),
		.round_idx(round_idx),
		.cipher_key(req.key),
		.round_key(round_key)
	);

	inv_round_path u_inv_round_path (
		.Clk(Clk),
		.arst_n(arst_n),
		.path_op(path_op),
		.ciphertext(req.ciphertext),
		.round_key(round_key),
		.state(plaintext)
	);

endmodule

// ==== tb/aes_decrypt_sva.sv ====
// aes_decrypt_sva: bound checks on the plaintext and on both handshakes of the AES decrypt core.
`timescale 1ns/1ns

module aes_decrypt_sva (
	input logic Clk,
	input logic arst_n,
	input logic in_valid,
	input logic in_ready,
	input aes_pkg::dec_req_t req,
	input logic out_valid,
	input logic out_ready,
	input aes_pkg::block_t plaintext
);
	import aes_pkg::*;

	int fail_count = 0;
	dec_req_t held_req;

	// known FIPS-197 vectors, keyed by the whole request.
	function automatic block_t expected_plain(input dec_req_t r);
		if (r.key == 128'h000102030405060708090a0b0c0d0e0f &&
			r.ciphertext == 128'h69c4e0d86a7b0430d8cdb78070b4c55a) begin
			return 128'h00112233445566778899aabbccddeeff;
		end
		if (r.key == 128'h2b7e151628aed2a6abf7158809cf4f3c &&
			r.ciphertext == 128'h3925841d02dc09fbdc118597196a0b32) begin
			return 128'h3243f6a8885a308d313198a2e0370734;
		end
		return 'x;
	endfunction

	function automatic string vector_name(input dec_req_t r);
		if (r.key == 128'h000102030405060708090a0b0c0d0e0f) begin
			return "fips197_c1";
		end
		if (r.key == 128'h2b7e151628aed2a6abf7158809cf4f3c) begin
			return "fips197_b";
		end
		return "unknown_vector";
	endfunction

	// the request in flight, kept until its result leaves the core.
	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			held_req <= '0;
		end else if (in_valid && in_ready) begin
			held_req <= req;
		end
	end

	// on the first edge out of reset the core is idle and offers no result.
	reset_idle: assert property (@(posedge Clk) $rose(arst_n) |-> (in_ready && !out_valid))
		else begin
			fail_count++;
			$error("ERROR reset: expected in_ready 1 out_valid 0, actual in_ready %b out_valid %b",
				$sampled(in_ready), $sampled(out_valid));
		end

	// out_valid comes up 21 cycles after the accepting edge and in_ready stays low meanwhile.
	latency: assert property (@(posedge Clk) disable iff (!arst_n)
		(in_valid && in_ready) |=> (!out_valid && !in_ready) [*21] ##1 (out_valid && !in_ready))
		else begin
			fail_count++;
			$error("out_valid did not rise exactly 21 cycles after the request was accepted");
		end

	busy_hold: assert property (@(posedge Clk) disable iff (!arst_n) out_valid |-> !in_ready)
		else begin
			fail_count++;
			$error("the core was ready for a new request while a result was still pending");
		end

	stall_hold: assert property (@(posedge Clk) disable iff (!arst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(plaintext)))
		else begin
			fail_count++;
			$error("out_valid or plaintext changed while the sink was stalling");
		end

	release_idle: assert property (@(posedge Clk) disable iff (!arst_n)
		(out_valid && out_ready) |=> (in_ready && !out_valid))
		else begin
			fail_count++;
			$error("the core did not return to idle after the result transfer");
		end

	plain_match: assert property (@(posedge Clk) disable iff (!arst_n)
		(out_valid && out_ready) |-> (plaintext === expected_plain(held_req)))
		else begin
			fail_count++;
			$error("ERROR %s: expected %h actual %h", vector_name($sampled(held_req)),
				expected_plain($sampled(held_req)), $sampled(plaintext));
		end

endmodule

bind aes_decrypt aes_decrypt_sva u_sva (
	.Clk(Clk),
	.arst_n(arst_n),
	.in_valid(in_valid),
	.in_ready(in_ready),
	.req(req),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.plaintext(plaintext)
);

// ==== tb/aes_decrypt_tb.sv ====
// aes_decrypt_tb: runs FIPS-197 vectors through the AES decrypt core with random gaps and stalls.
`timescale 1ns/1ns

module aes_decrypt_tb;
	import aes_pkg::*;

	localparam int TIMEOUT = 100;
	localparam block_t C1_KEY = 128'h000102030405060708090a0b0c0d0e0f;
	localparam block_t C1_CT = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam block_t B_KEY = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam block_t B_CT = 128'h3925841d02dc09fbdc118597196a0b32;

	logic Clk;
	logic arst_n;
	logic in_valid;
	logic in_ready;
	dec_req_t req;
	logic out_valid;
	logic out_ready;
	block_t plaintext;

	logic [31:0] lfsr;
	int tests_run;
	int tests_failed;
	int fails_before;
	bit timed_out;

	aes_decrypt dut (
		.Clk(Clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.req(req),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.plaintext(plaintext)
	);

	initial Clk = 1'b0;
	always #20 Clk = ~Clk;

	// Galois LFSR for x^32 + x^22 + x^2 + x + 1, one step per bit taken.
	function automatic int take_bits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | lfsr[0];
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return value;
	endfunction

	// called on a falling edge; returns on the falling edge after the accepting edge.
	task automatic send_request(input block_t key, input block_t ct, input int gap);
		int waited;
		waited = 0;
		repeat (gap) @(negedge Clk);
		in_valid = 1'b1;
		req.key = key;
		req.ciphertext = ct;
		while (!in_ready && waited < TIMEOUT) begin
			@(negedge Clk);
			waited++;
		end
		if (!in_ready) begin
			$display("timeout: the core never accepted the request");
			timed_out = 1'b1;
		end
		@(negedge Clk);
		in_valid = 1'b0;
	endtask

	task automatic receive_result(input int stall);
		int waited;
		waited = 0;
		out_ready = 1'b0;
		while (!out_valid && waited < TIMEOUT) begin
			@(negedge Clk);
			waited++;
		end
		if (!out_valid) begin
			$display("timeout: the core never offered a result");
			timed_out = 1'b1;
		end else begin
			repeat (stall) @(negedge Clk);
			out_ready = 1'b1;
			@(negedge Clk);
			out_ready = 1'b0;
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (timed_out || dut.u_sva.fail_count != fails_before) begin
			tests_failed++;
			$display("test %s: failed", name);
		end else begin
			$display("test %s: ok", name);
		end
		timed_out = 1'b0;
		fails_before = dut.u_sva.fail_count;
	endtask

	initial begin
		int gap;
		int stall;
		lfsr = 32'hd80c304f;
		arst_n = 1'b0;
		in_valid = 1'b0;
		req = '0;
		out_ready = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		fails_before = 0;
		timed_out = 1'b0;

		repeat (16) @(negedge Clk);
		arst_n = 1'b1;
		// the idle flags are checked on the first rising edge out of reset.
		@(negedge Clk);
		report_test("reset");

		gap = take_bits(3);
		stall = take_bits(4);
		send_request(C1_KEY, C1_CT, gap);
		receive_result(stall);
		report_test("fips197_c1");

		// Next vector goes in right after the transfer, with a different key.
		stall = take_bits(4);
		send_request(B_KEY, B_CT, 0);
		receive_result(stall);
		report_test("fips197_b");

		// a second request waits at the input while the sink stalls the first result.
		gap = take_bits(3);
		stall = take_bits(4);
		stall = stall + 4;
		send_request(C1_KEY, C1_CT, gap);
		fork
			receive_result(stall);
			send_request(B_KEY, B_CT, 22);
		join
		receive_result(0);
		report_test("backpressure");

		$display("tests run %0d, failed %0d", tests_run, tests_failed);
		if (tests_failed == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
common/aes_pkg.sv
hw/inv_round/inv_sbox.sv
hw/inv_round/inv_mix_column.sv
hw/inv_round/inv_round_path.sv
hw/key_schedule/sbox_word.sv
hw/key_schedule/key_schedule.sv
hw/aes_decrypt_ctrl.sv
hw/aes_decrypt.sv
tb/aes_decrypt_sva.sv
tb/aes_decrypt_tb.sv
